// ==== files.f ====
logic/mem_pkg.sv
logic/bank_router.sv
logic/dram_bank.sv
logic/reply_merge.sv
logic/mem_subsystem.sv
test/clk_gen.sv
test/mem_chk.sv
test/mem_tb.sv

// ==== logic/bank_router.sv ====
module bank_router (
    input  logic                               req_valid,
    input  logic [mem_pkg::addr_bits-1:0]      req_addr,
    input  logic [mem_pkg::num_banks-1:0]      busy,
    output logic [mem_pkg::num_banks-1:0]      bank_valid,
    output logic                               stall
);

    logic [mem_pkg::bank_sel_bits-1:0] sel;       // Addressed bank
    logic [mem_pkg::num_banks-1:0]     sel_hot;   // One-hot form of sel
    logic                              sel_busy;

    assign sel = req_addr[mem_pkg::bank_sel_lsb +: mem_pkg::bank_sel_bits];

    // Decode the select field
    always_comb begin
        sel_hot = '0;
        for (int i = 0; i < mem_pkg::num_banks; i++) begin
            if (sel == i[mem_pkg::bank_sel_bits-1:0]) begin
                sel_hot[i] = 1'b1;
            end
        end
    end

    // Busy level of the addressed bank
    always_comb begin
        sel_busy = 1'b0;
        for (int i = 0; i < mem_pkg::num_banks; i++) begin
            if (sel_hot[i]) begin
                sel_busy = busy[i];
            end
        end
    end

    // Strobe goes only to an idle addressed bank
    always_comb begin
        for (int i = 0; i < mem_pkg::num_banks; i++) begin
            bank_valid[i] = req_valid && sel_hot[i] && !busy[i];
        end
    end

    assign stall = req_valid && sel_busy;         // Requester holds its fields

endmodule

// ==== logic/dram_bank.sv ====
module dram_bank (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               bank_valid,
    input  logic [mem_pkg::addr_bits-1:0]      req_addr,
    input  logic [mem_pkg::op_bits-1:0]        req_op,
    input  logic [mem_pkg::id_bits-1:0]        req_src,
    input  logic [mem_pkg::line_bits-1:0]      req_data,
    output logic                               busy,
    output logic                               rep_valid,
    output logic [mem_pkg::addr_bits-1:0]      rep_addr,
    output logic [mem_pkg::op_bits-1:0]        rep_op,
    output logic [mem_pkg::id_bits-1:0]        rep_dest,
    output logic [mem_pkg::line_bits-1:0]      rep_data
);

    // Line storage
    logic [mem_pkg::line_bits-1:0] mem [0:(1 << mem_pkg::index_bits)-1];

    // Latency countdown, zero means idle
    logic [$clog2(mem_pkg::bank_latency+1)-1:0] cnt;

    // Request latch
    logic [mem_pkg::addr_bits-1:0] addr_buf;
    logic [mem_pkg::op_bits-1:0]   op_buf;
    logic [mem_pkg::id_bits-1:0]   src_buf;
    logic [mem_pkg::line_bits-1:0] data_buf;

    logic                           accept;
    logic                           last;
    logic                           is_wr;
    logic [mem_pkg::index_bits-1:0] index;

    // A noop strobe is dropped and starts no busy period
    assign accept = bank_valid && (cnt == '0) && (req_op != mem_pkg::op_noop);
    assign last   = (cnt == 'd1);
    assign is_wr  = (op_buf == mem_pkg::op_wr);
    assign index  = addr_buf[mem_pkg::index_lsb +: mem_pkg::index_bits];
    assign busy   = (cnt != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt <= '0;
        end else if (accept) begin
            cnt <= ($bits(cnt))'(mem_pkg::bank_latency);
        end else if (cnt != '0) begin
            cnt <= cnt - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            addr_buf <= req_addr;
            op_buf   <= req_op;
            src_buf  <= req_src;
            data_buf <= req_data;
        end
    end

    // Writes complete silently
    always_ff @(posedge clk) begin
        if (rst) begin
            rep_valid <= 1'b0;
        end else begin
            rep_valid <= last && !is_wr;
        end
    end

    // Final state, array access and reply payload
    always_ff @(posedge clk) begin
        if (last) begin
            rep_data <= mem[index];                 // Old line on a write
            rep_addr <= addr_buf;
            rep_op   <= mem_pkg::op_reply;
            rep_dest <= src_buf;
            if (is_wr) begin
                mem[index] <= data_buf;
            end
        end
    end

endmodule

// ==== logic/mem_pkg.sv ====
package mem_pkg;

    // Widths of the request and reply fields
    localparam int line_bits = 128;                // One cache line
    localparam int addr_bits = 32;
    localparam int op_bits   = 3;
    localparam int id_bits   = 2;

    // Operation codes
    localparam logic [op_bits-1:0] op_noop  = 3'd0;
    localparam logic [op_bits-1:0] op_reply = 3'd2;  // Memory answer to a read
    localparam logic [op_bits-1:0] op_rd    = 3'd3;
    localparam logic [op_bits-1:0] op_wr    = 3'd4;
    localparam logic [op_bits-1:0] op_inv   = 3'd5;  // Served as a read by the banks
    localparam logic [op_bits-1:0] op_upd   = 3'd6;
    localparam logic [op_bits-1:0] op_rwitm = 3'd7;  // Served as a read by the banks

    // Source id that memory puts on its replies
    localparam logic [id_bits-1:0] mem_id = 2'd3;

    // Line index inside one bank
    localparam int index_lsb  = 5;
    localparam int index_bits = 12;                // 4096 lines per bank

    // Bank decode, the select field sits just above the index
    localparam int num_banks     = 2;
    localparam int bank_sel_bits = $clog2(num_banks);
    localparam int bank_sel_lsb  = 17;

    // Cycles from acceptance to the reply register
    localparam int bank_latency = 6;

endpackage

// ==== logic/mem_subsystem.sv ====
module mem_subsystem (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               req_valid,
    input  logic [mem_pkg::addr_bits-1:0]      req_addr,
    input  logic [mem_pkg::op_bits-1:0]        req_op,
    input  logic [mem_pkg::id_bits-1:0]        req_src,
    input  logic [mem_pkg::line_bits-1:0]      req_data,
    output logic                               stall,
    output logic                               resp_valid,
    output logic [mem_pkg::addr_bits-1:0]      resp_addr,
    output logic [mem_pkg::op_bits-1:0]        resp_op,
    output logic [mem_pkg::id_bits-1:0]        resp_src,
    output logic [mem_pkg::id_bits-1:0]        resp_dest,
    output logic [mem_pkg::line_bits-1:0]      resp_data
);

    logic [mem_pkg::num_banks-1:0] bank_valid;
    logic [mem_pkg::num_banks-1:0] busy;

    // Per-bank reply wires
    logic [mem_pkg::num_banks-1:0]                          rep_valid;
    logic [mem_pkg::num_banks-1:0][mem_pkg::addr_bits-1:0]  rep_addr;
    logic [mem_pkg::num_banks-1:0][mem_pkg::op_bits-1:0]    rep_op;
    logic [mem_pkg::num_banks-1:0][mem_pkg::id_bits-1:0]    rep_dest;
    logic [mem_pkg::num_banks-1:0][mem_pkg::line_bits-1:0]  rep_data;

    assign resp_src = mem_pkg::mem_id;            // Every reply comes from memory

    bank_router u_router (
        .req_valid  (req_valid),
        .req_addr   (req_addr),
        .busy       (busy),
        .bank_valid (bank_valid),
        .stall      (stall)
    );

    for (genvar i = 0; i < mem_pkg::num_banks; i++) begin : g_bank
        dram_bank u_bank (
            .clk        (clk),
            .rst        (rst),
            .bank_valid (bank_valid[i]),
            .req_addr   (req_addr),          // Fields broadcast to all banks
            .req_op     (req_op),
            .req_src    (req_src),
            .req_data   (req_data),
            .busy       (busy[i]),
            .rep_valid  (rep_valid[i]),
            .rep_addr   (rep_addr[i]),
            .rep_op     (rep_op[i]),
            .rep_dest   (rep_dest[i]),
            .rep_data   (rep_data[i])
        );
    end

    reply_merge u_merge (
        .clk        (clk),
        .rst        (rst),
        .rep_valid  (rep_valid),
        .rep_addr   (rep_addr),
        .rep_op     (rep_op),
        .rep_dest   (rep_dest),
        .rep_data   (rep_data),
        .resp_valid (resp_valid),
        .resp_addr  (resp_addr),
        .resp_op    (resp_op),
        .resp_dest  (resp_dest),
        .resp_data  (resp_data)
    );

endmodule

// ==== logic/reply_merge.sv ====
module reply_merge (
    input  logic                                               clk,
    input  logic                                               rst,
    input  logic [mem_pkg::num_banks-1:0]                      rep_valid,
    input  logic [mem_pkg::num_banks-1:0][mem_pkg::addr_bits-1:0] rep_addr,
    input  logic [mem_pkg::num_banks-1:0][mem_pkg::op_bits-1:0]   rep_op,
    input  logic [mem_pkg::num_banks-1:0][mem_pkg::id_bits-1:0]   rep_dest,
    input  logic [mem_pkg::num_banks-1:0][mem_pkg::line_bits-1:0] rep_data,
    output logic                                               resp_valid,
    output logic [mem_pkg::addr_bits-1:0]                      resp_addr,
    output logic [mem_pkg::op_bits-1:0]                        resp_op,
    output logic [mem_pkg::id_bits-1:0]                        resp_dest,
    output logic [mem_pkg::line_bits-1:0]                      resp_data
);

    // One holder per bank
    logic [mem_pkg::num_banks-1:0]                          full;
    logic [mem_pkg::num_banks-1:0][mem_pkg::addr_bits-1:0]  h_addr;
    logic [mem_pkg::num_banks-1:0][mem_pkg::op_bits-1:0]    h_op;
    logic [mem_pkg::num_banks-1:0][mem_pkg::id_bits-1:0]    h_dest;
    logic [mem_pkg::num_banks-1:0][mem_pkg::line_bits-1:0]  h_data;

    logic [mem_pkg::bank_sel_bits-1:0] ptr;       // Round-robin start
    logic [mem_pkg::bank_sel_bits-1:0] pick;
    logic [mem_pkg::bank_sel_bits-1:0] pick_next;
    logic                              pick_ok;

    // First full holder at or after ptr
    always_comb begin
        logic [mem_pkg::bank_sel_bits:0] idx;
        pick    = ptr;
        pick_ok = 1'b0;
        for (int k = 0; k < mem_pkg::num_banks; k++) begin
            idx = {1'b0, ptr} + k[mem_pkg::bank_sel_bits:0];
            if (idx >= mem_pkg::num_banks) begin
                idx = idx - (mem_pkg::bank_sel_bits + 1)'(mem_pkg::num_banks);
            end
            if (!pick_ok && full[idx[mem_pkg::bank_sel_bits-1:0]]) begin
                pick    = idx[mem_pkg::bank_sel_bits-1:0];
                pick_ok = 1'b1;
            end
        end
    end

    // Pointer moves past the chosen bank, with wrap
    assign pick_next = (pick == (mem_pkg::bank_sel_bits)'(mem_pkg::num_banks - 1)) ?
                       '0 : pick + 1'b1;

    always_ff @(posedge clk) begin
        if (rst) begin
            full       <= '0;
            ptr        <= '0;
            resp_valid <= 1'b0;
        end else begin
            for (int i = 0; i < mem_pkg::num_banks; i++) begin
                if (rep_valid[i]) begin
                    full[i] <= 1'b1;                // New pulse wins over a clear
                end else if (pick_ok && (pick == i[mem_pkg::bank_sel_bits-1:0])) begin
                    full[i] <= 1'b0;
                end
            end
            if (pick_ok) begin
                ptr <= pick_next;
            end
            resp_valid <= pick_ok;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < mem_pkg::num_banks; i++) begin
            if (rep_valid[i]) begin
                h_addr[i] <= rep_addr[i];
                h_op[i]   <= rep_op[i];
                h_dest[i] <= rep_dest[i];
                h_data[i] <= rep_data[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pick_ok) begin
            resp_addr <= h_addr[pick];
            resp_op   <= h_op[pick];
            resp_dest <= h_dest[pick];
            resp_data <= h_data[pick];
        end
    end

endmodule

// ==== test/clk_gen.sv ====
module clk_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;                 // Period 100
    end

    initial begin
        rst = 1'b1;
        repeat (2) @(posedge clk);
        #10 rst = 1'b0;                         // Released with the stimulus offset
    end

endmodule

// ==== test/mem_chk.sv ====
module mem_chk (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               req_valid,
    input  logic [mem_pkg::addr_bits-1:0]      req_addr,
    input  logic [mem_pkg::op_bits-1:0]        req_op,
    input  logic [mem_pkg::id_bits-1:0]        req_src,
    input  logic [mem_pkg::line_bits-1:0]      req_data,
    input  logic                               stall,
    input  logic [mem_pkg::num_banks-1:0]      busy,
    input  logic                               resp_valid,
    input  logic [mem_pkg::addr_bits-1:0]      resp_addr,
    input  logic [mem_pkg::op_bits-1:0]        resp_op,
    input  logic [mem_pkg::id_bits-1:0]        resp_src,
    input  logic [mem_pkg::id_bits-1:0]        resp_dest,
    input  logic [mem_pkg::line_bits-1:0]      resp_data
);

    localparam int lines    = mem_pkg::num_banks << mem_pkg::index_bits;
    localparam int idle_gap = mem_pkg::bank_latency + 1;
    // Sampling edges from acceptance to the edge that sees resp_valid
    localparam int lat_lo   = mem_pkg::bank_latency + 3;
    localparam int lat_hi   = mem_pkg::bank_latency + 2 + mem_pkg::num_banks;

    int fail_count = 0;                         // Bumped by every failing assertion
    int reads;
    int replies;
    int cyc;

    logic [mem_pkg::line_bits-1:0] shadow [0:lines-1];

    // Outstanding reads per bank, oldest first
    logic [mem_pkg::addr_bits-1:0] q_addr [mem_pkg::num_banks][4];
    logic [mem_pkg::id_bits-1:0]   q_src  [mem_pkg::num_banks][4];
    logic [mem_pkg::line_bits-1:0] q_data [mem_pkg::num_banks][4];
    int                            q_cyc  [mem_pkg::num_banks][4];
    logic [2:0]                    wp     [mem_pkg::num_banks];
    logic [2:0]                    rp     [mem_pkg::num_banks];

    int                            since  [mem_pkg::num_banks];  // Cycles since last accept
    logic [mem_pkg::num_banks-1:0] model_busy;

    logic [mem_pkg::bank_sel_bits-1:0] req_bank;
    logic [mem_pkg::bank_sel_bits-1:0] resp_bank;
    logic [mem_pkg::index_bits-1:0]    req_index;
    int                                req_line;
    logic                              take;
    logic [2:0]                        resp_cnt;
    logic [mem_pkg::addr_bits-1:0]     exp_addr;
    logic [mem_pkg::id_bits-1:0]       exp_src;
    logic [mem_pkg::line_bits-1:0]     exp_data;
    int                                exp_cyc;

    assign req_bank  = req_addr[mem_pkg::bank_sel_lsb +: mem_pkg::bank_sel_bits];
    assign req_index = req_addr[mem_pkg::index_lsb +: mem_pkg::index_bits];
    assign req_line  = (int'(req_bank) << mem_pkg::index_bits) + int'(req_index);
    assign take      = req_valid && !stall && (req_op != mem_pkg::op_noop);
    assign resp_bank = resp_addr[mem_pkg::bank_sel_lsb +: mem_pkg::bank_sel_bits];
    assign resp_cnt  = wp[resp_bank] - rp[resp_bank];
    assign exp_addr  = q_addr[resp_bank][rp[resp_bank][1:0]];
    assign exp_src   = q_src[resp_bank][rp[resp_bank][1:0]];
    assign exp_data  = q_data[resp_bank][rp[resp_bank][1:0]];
    assign exp_cyc   = q_cyc[resp_bank][rp[resp_bank][1:0]];

    always_comb begin
        for (int b = 0; b < mem_pkg::num_banks; b++) begin
            model_busy[b] = (since[b] < idle_gap);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cyc     <= 0;
            reads   <= 0;
            replies <= 0;
            for (int b = 0; b < mem_pkg::num_banks; b++) begin
                wp[b]    <= '0;
                rp[b]    <= '0;
                since[b] <= idle_gap;
            end
        end else begin
            cyc <= cyc + 1;
            for (int b = 0; b < mem_pkg::num_banks; b++) begin
                if (since[b] < idle_gap) begin
                    since[b] <= since[b] + 1;
                end
            end
            if (take) begin
                since[req_bank] <= 1;
                if (req_op == mem_pkg::op_wr) begin
                    shadow[req_line] <= req_data;
                end else begin
                    q_addr[req_bank][wp[req_bank][1:0]] <= req_addr;
                    q_src[req_bank][wp[req_bank][1:0]]  <= req_src;
                    q_data[req_bank][wp[req_bank][1:0]] <= shadow[req_line];
                    q_cyc[req_bank][wp[req_bank][1:0]]  <= cyc;
                    wp[req_bank] <= wp[req_bank] + 1'b1;
                    reads        <= reads + 1;
                end
            end
            if (resp_valid) begin
                rp[resp_bank] <= rp[resp_bank] + 1'b1;
                replies       <= replies + 1;
            end
        end
    end

    a_reset: assert property (@(posedge clk) rst |=> !resp_valid && !stall && busy == '0)
        else begin
            fail_count++;
            $error("Error %0t: reply, stall or busy active right after reset", $time);
        end

    a_stall: assert property (@(posedge clk) disable iff (rst)
        stall == (req_valid && model_busy[req_bank]))
        else begin
            fail_count++;
            $error("Error %0t: stall is %b for bank %0d", $time, stall, req_bank);
        end

    a_busy: assert property (@(posedge clk) disable iff (rst) busy == model_busy)
        else begin
            fail_count++;
            $error("Error %0t: busy %b, expected %b", $time, busy, model_busy);
        end

    a_orphan: assert property (@(posedge clk) disable iff (rst) resp_valid |-> resp_cnt != 0)
        else begin
            fail_count++;
            $error("Error %0t: reply with no read outstanding in bank %0d", $time, resp_bank);
        end

    a_data: assert property (@(posedge clk) disable iff (rst)
        resp_valid |-> resp_data == exp_data)
        else begin
            fail_count++;
            $error("Error %0t: resp_data %h, expected %h", $time, resp_data, exp_data);
        end

    a_fields: assert property (@(posedge clk) disable iff (rst)
        resp_valid |-> resp_addr == exp_addr && resp_dest == exp_src &&
                       resp_op == mem_pkg::op_reply && resp_src == mem_pkg::mem_id)
        else begin
            fail_count++;
            $error("Error %0t: reply header addr %h op %0d src %0d dest %0d", $time,
                   resp_addr, resp_op, resp_src, resp_dest);
        end

    a_latency: assert property (@(posedge clk) disable iff (rst)
        resp_valid |-> (cyc - exp_cyc) inside {[lat_lo:lat_hi]})
        else begin
            fail_count++;
            $error("Error %0t: reply after %0d cycles", $time, cyc - exp_cyc);
        end

endmodule

// ==== test/mem_tb.sv ====
module mem_tb;

    localparam int n_lines     = 8;             // Random writes
    localparam int n_reads     = 12;            // Random reads of written lines
    localparam int n_req       = 1 + n_lines + n_reads + 6;
    localparam int cycle_limit = 40 * n_req + 50;

    logic                               clk;
    logic                               rst;
    logic                               req_valid;
    logic [mem_pkg::addr_bits-1:0]      req_addr;
    logic [mem_pkg::op_bits-1:0]        req_op;
    logic [mem_pkg::id_bits-1:0]        req_src;
    logic [mem_pkg::line_bits-1:0]      req_data;
    logic                               stall;
    logic                               resp_valid;
    logic [mem_pkg::addr_bits-1:0]      resp_addr;
    logic [mem_pkg::op_bits-1:0]        resp_op;
    logic [mem_pkg::id_bits-1:0]        resp_src;
    logic [mem_pkg::id_bits-1:0]        resp_dest;
    logic [mem_pkg::line_bits-1:0]      resp_data;

    int seed         = 32'h6097f9e7;
    int cycles       = 0;
    int timeouts     = 0;
    int end_errors   = 0;
    int reads_issued = 0;
    int replies_seen = 0;

    logic [mem_pkg::addr_bits-1:0] written [n_lines];

    clk_gen u_clk (
        .clk (clk),
        .rst (rst)
    );

    mem_subsystem uut (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid),
        .req_addr   (req_addr),
        .req_op     (req_op),
        .req_src    (req_src),
        .req_data   (req_data),
        .stall      (stall),
        .resp_valid (resp_valid),
        .resp_addr  (resp_addr),
        .resp_op    (resp_op),
        .resp_src   (resp_src),
        .resp_dest  (resp_dest),
        .resp_data  (resp_data)
    );

    bind mem_subsystem mem_chk u_chk (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid),
        .req_addr   (req_addr),
        .req_op     (req_op),
        .req_src    (req_src),
        .req_data   (req_data),
        .stall      (stall),
        .busy       (busy),
        .resp_valid (resp_valid),
        .resp_addr  (resp_addr),
        .resp_op    (resp_op),
        .resp_src   (resp_src),
        .resp_dest  (resp_dest),
        .resp_data  (resp_data)
    );

    function automatic logic [mem_pkg::addr_bits-1:0] line_addr(input int bank, input int index);
        logic [mem_pkg::addr_bits-1:0] a;
        a = '0;
        a[mem_pkg::bank_sel_lsb +: mem_pkg::bank_sel_bits] = bank[mem_pkg::bank_sel_bits-1:0];
        a[mem_pkg::index_lsb +: mem_pkg::index_bits] = index[mem_pkg::index_bits-1:0];
        return a;
    endfunction

    function automatic logic [mem_pkg::line_bits-1:0] random_line();
        return {$random(seed), $random(seed), $random(seed), $random(seed)};
    endfunction

    // Holds the request until a rising edge sees stall low
    task automatic send(input logic [mem_pkg::op_bits-1:0]   op,
                        input logic [mem_pkg::addr_bits-1:0] addr,
                        input logic [mem_pkg::id_bits-1:0]   src,
                        input logic [mem_pkg::line_bits-1:0] data);
        logic held;
        req_valid = 1'b1;
        req_op    = op;
        req_addr  = addr;
        req_src   = src;
        req_data  = data;
        do begin
            @(negedge clk);
            held = stall;
            @(posedge clk);
            #10;
        end while (held);
        if (op != mem_pkg::op_noop && op != mem_pkg::op_wr) begin
            reads_issued++;
        end
    endtask

    task automatic pause(input int n);
        req_valid = 1'b0;
        repeat (n) begin
            @(posedge clk);
            #10;
        end
    endtask

    task automatic drain();
        req_valid = 1'b0;
        while (replies_seen < reads_issued) begin
            @(posedge clk);
            #10;
        end
        pause(2 * mem_pkg::bank_latency);       // Room for a stray reply to show up
    endtask

    task automatic finish_run();
        int failures;
        failures = uut.u_chk.fail_count + end_errors + timeouts;
        $display("Assertion failures: %0d, end of run failures: %0d, timeouts: %0d",
                 uut.u_chk.fail_count, end_errors, timeouts);
        if (failures == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    endtask

    always @(posedge clk) begin
        if (!rst && resp_valid) begin
            replies_seen++;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            timeouts++;
            $display("Run stopped after %0d cycles with %0d of %0d replies received",
                     cycles, replies_seen, reads_issued);
            finish_run();
        end
    end

    initial begin
        int bank;
        int index;
        int pick;
        logic [mem_pkg::op_bits-1:0] read_ops [3];
        read_ops  = '{mem_pkg::op_rd, mem_pkg::op_inv, mem_pkg::op_rwitm};
        req_valid = 1'b0;
        req_addr  = '0;
        req_op    = mem_pkg::op_noop;
        req_src   = '0;
        req_data  = '0;
        @(negedge rst);

        send(mem_pkg::op_noop, line_addr(0, 0), 2'd0, '0);  // No reply, no busy period

        for (int i = 0; i < n_lines; i++) begin
            bank       = $unsigned($random(seed)) % mem_pkg::num_banks;
            index      = $unsigned($random(seed)) % (1 << mem_pkg::index_bits);
            written[i] = line_addr(bank, index);
            send(mem_pkg::op_wr, written[i], 2'd1, random_line());
        end

        // Back-to-back reads, same bank neighbours stall
        for (int i = 0; i < n_reads; i++) begin
            pick = $unsigned($random(seed)) % n_lines;
            send(read_ops[$unsigned($random(seed)) % 3], written[pick],
                 $random(seed), random_line());
        end

        // One line in each bank, then overlapping reads
        send(mem_pkg::op_wr, line_addr(0, 12'h0a5), 2'd2, random_line());
        send(mem_pkg::op_wr, line_addr(1, 12'h0a5), 2'd2, random_line());
        pause(mem_pkg::bank_latency + 2);
        send(mem_pkg::op_rd, line_addr(0, 12'h0a5), 2'd0, '0);
        send(mem_pkg::op_rd, line_addr(1, 12'h0a5), 2'd1, '0);
        send(mem_pkg::op_rwitm, line_addr(0, 12'h0a5), 2'd2, '0);
        send(mem_pkg::op_inv, line_addr(1, 12'h0a5), 2'd0, '0);

        drain();
        assert (uut.u_chk.replies == uut.u_chk.reads && replies_seen == reads_issued)
            else begin
                end_errors++;
                $error("Error %0t: %0d replies for %0d accepted reads", $time,
                       uut.u_chk.replies, uut.u_chk.reads);
            end
        finish_run();
    end

endmodule
